// ==== common/eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

    ////////////////////////////////////////////////////////////
    // frame format
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;   // start of frame delimiter

    // preamble plus sfd
    localparam int PREAMBLE_LEN = 8;
    localparam int CRC_LEN      = 4;

    // reflected form of the 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    ////////////////////////////////////////////////////////////
    // transmit sequencing
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        PH_IDLE,        // wait for a descriptor
        PH_PTR,         // descriptor word on the fifo output
        PH_PREAMBLE,
        PH_DATA,
        PH_CRC,
        PH_IFG          // inter frame gap
    } tx_phase_t;

    // gmii transmit pins
    typedef struct packed {
        logic       dv;
        logic [7:0] d;
    } gmii_tx_t;

endpackage

`default_nettype wire

// ==== common/tx_queue_pkg.sv ====
`default_nettype none

package tx_queue_pkg;

    localparam int LEN_W = 11;      // frame length field, bytes

    // one word of the pointer fifo per frame
    typedef struct packed {
        logic [4:0]       rsvd;
        logic [LEN_W-1:0] len;
    } tx_ptr_t;

    // fifo pair outputs, registered on the fifo side
    typedef struct packed {
        logic [7:0] data;
        logic       data_empty;
        tx_ptr_t    ptr;
        logic       ptr_empty;
    } queue_in_t;

    // one cycle read strobes
    typedef struct packed {
        logic data_rd;
        logic ptr_rd;
    } queue_rd_t;

    typedef enum logic {
        SEL_NORM,
        SEL_TTE
    } queue_sel_t;

endpackage

`default_nettype wire

// ==== crc/crc32_8023.sv ====
`timescale 1ns/100ps
`default_nettype none

module crc32_8023 (
    input  wire                           tx_master_clk,
    input  wire                           rstn_mac,
    input  wire eth_frame_pkg::tx_phase_t phase,
    input  wire [7:0]                     d,
    output logic [7:0]                    crc_byte
);

    logic [31:0] crc;

    // one byte through the reflected lfsr, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ b[i]) begin
                r = (r >> 1) ^ eth_frame_pkg::CRC_POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // crc register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc <= eth_frame_pkg::CRC_INIT;
        end else begin
            case (phase)
                eth_frame_pkg::PH_PREAMBLE: crc <= eth_frame_pkg::CRC_INIT;
                eth_frame_pkg::PH_DATA:     crc <= crc_step(crc, d);
                eth_frame_pkg::PH_CRC:      crc <= crc >> 8;    // next check byte down
                default:                    crc <= crc;
            endcase
        end
    end

    // complemented result, lowest byte on the wire first
    assign crc_byte = ~crc[7:0];

endmodule

`default_nettype wire

// ==== hdl/tx_byte_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_byte_counter (
    input  wire                              tx_master_clk,
    input  wire                              rstn_mac,
    input  wire                              load,
    input  wire [tx_queue_pkg::LEN_W-1:0]    load_value,
    output logic                             last
);

    logic [tx_queue_pkg::LEN_W-1:0] remain;    // bytes left in this phase

    // span starts the cycle after the load
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            remain <= '0;
        end else if (load) begin
            remain <= load_value;
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // one byte to go
    assign last = (remain == tx_queue_pkg::LEN_W'(1));

endmodule

`default_nettype wire

// ==== hdl/tx_data_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_data_path (
    input  wire                            tx_master_clk,
    input  wire                            rstn_mac,
    input  wire eth_frame_pkg::tx_phase_t  phase,
    input  wire tx_queue_pkg::queue_sel_t  sel,
    input  wire [7:0]                      norm_data,
    input  wire [7:0]                      tte_data,
    output eth_frame_pkg::gmii_tx_t        gmii
);

    logic [7:0]              q_byte;        // payload of the active queue
    logic [7:0]              crc_byte;
    logic [2:0]              pre_idx;       // position inside the preamble
    eth_frame_pkg::gmii_tx_t gmii_next;

    assign q_byte = (sel == tx_queue_pkg::SEL_TTE) ? tte_data : norm_data;

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            pre_idx <= 3'd0;
        end else begin
            pre_idx <= (phase == eth_frame_pkg::PH_PREAMBLE) ? pre_idx + 3'd1 : 3'd0;
        end
    end

    ////////////////////////////////////////////////////////////
    // output byte select
    ////////////////////////////////////////////////////////////

    always_comb begin
        gmii_next.dv = 1'b1;
        case (phase)
            eth_frame_pkg::PH_PREAMBLE: begin
                // sfd closes the preamble
                if (pre_idx == 3'(eth_frame_pkg::PREAMBLE_LEN - 1)) begin
                    gmii_next.d = eth_frame_pkg::SFD_BYTE;
                end else begin
                    gmii_next.d = eth_frame_pkg::PREAMBLE_BYTE;
                end
            end
            eth_frame_pkg::PH_DATA: gmii_next.d = q_byte;
            eth_frame_pkg::PH_CRC:  gmii_next.d = crc_byte;   // fcs, low byte first
            default: begin
                gmii_next.dv = 1'b0;
                gmii_next.d  = 8'h00;
            end
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            gmii <= '0;
        end else begin
            gmii <= gmii_next;
        end
    end

    crc32_8023 u_crc32_8023 (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .phase         (phase),
        .d             (q_byte),
        .crc_byte      (crc_byte)
    );

endmodule

`default_nettype wire

// ==== hdl/tx_frame_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_frame_fsm #(
    parameter int IFG_BYTES = 12
) (
    input  wire                          tx_master_clk,
    input  wire                          rstn_mac,
    input  wire                          norm_ptr_empty,
    input  wire                          tte_ptr_empty,
    input  wire tx_queue_pkg::tx_ptr_t   norm_ptr,
    input  wire tx_queue_pkg::tx_ptr_t   tte_ptr,
    input  wire                          last,
    output logic                         load,
    output logic [tx_queue_pkg::LEN_W-1:0] load_value,
    output eth_frame_pkg::tx_phase_t     phase,
    output tx_queue_pkg::queue_sel_t     sel,
    output tx_queue_pkg::queue_rd_t      norm_rd,
    output tx_queue_pkg::queue_rd_t      tte_rd
);

    localparam int LEN_W = tx_queue_pkg::LEN_W;

    eth_frame_pkg::tx_phase_t phase_next;
    logic                     ptr_rd;       // pointer strobe, one cycle
    logic                     data_rd;
    logic [LEN_W-1:0]         len;          // payload bytes of this frame

    ////////////////////////////////////////////////////////////
    // phase sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        phase_next = phase;
        case (phase)
            eth_frame_pkg::PH_IDLE: begin
                if (ptr_rd) begin
                    phase_next = eth_frame_pkg::PH_PTR;
                end
            end
            eth_frame_pkg::PH_PTR:      phase_next = eth_frame_pkg::PH_PREAMBLE;
            eth_frame_pkg::PH_PREAMBLE: if (last) phase_next = eth_frame_pkg::PH_DATA;
            eth_frame_pkg::PH_DATA:     if (last) phase_next = eth_frame_pkg::PH_CRC;
            eth_frame_pkg::PH_CRC:      if (last) phase_next = eth_frame_pkg::PH_IFG;
            eth_frame_pkg::PH_IFG:      if (last) phase_next = eth_frame_pkg::PH_IDLE;
            default:                    phase_next = eth_frame_pkg::PH_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            phase  <= eth_frame_pkg::PH_IDLE;
            ptr_rd <= 1'b0;
            sel    <= tx_queue_pkg::SEL_NORM;
        end else begin
            phase  <= phase_next;
            // arm once per idle period, tte wins
            ptr_rd <= (phase == eth_frame_pkg::PH_IDLE) && !ptr_rd &&
                      !(norm_ptr_empty && tte_ptr_empty);
            if ((phase == eth_frame_pkg::PH_IDLE) && !ptr_rd) begin
                sel <= tte_ptr_empty ? tx_queue_pkg::SEL_NORM : tx_queue_pkg::SEL_TTE;
            end
        end
    end

    // descriptor is valid on the fifo output during PH_PTR
    always_ff @(posedge tx_master_clk) begin
        if (phase == eth_frame_pkg::PH_PTR) begin
            len <= (sel == tx_queue_pkg::SEL_TTE) ? tte_ptr.len : norm_ptr.len;
        end
    end

    ////////////////////////////////////////////////////////////
    // counter loads, one per phase change
    ////////////////////////////////////////////////////////////

    always_comb begin
        load = (phase == eth_frame_pkg::PH_PTR) ||
               (last && ((phase == eth_frame_pkg::PH_PREAMBLE) ||
                         (phase == eth_frame_pkg::PH_DATA) ||
                         (phase == eth_frame_pkg::PH_CRC)));
        case (phase)
            eth_frame_pkg::PH_PTR:      load_value = LEN_W'(eth_frame_pkg::PREAMBLE_LEN);
            eth_frame_pkg::PH_PREAMBLE: load_value = len;
            eth_frame_pkg::PH_DATA:     load_value = LEN_W'(eth_frame_pkg::CRC_LEN);
            default:                    load_value = LEN_W'(IFG_BYTES);
        endcase
    end

    // strobe runs one cycle ahead of the bytes on the wire
    assign data_rd = ((phase == eth_frame_pkg::PH_PREAMBLE) && last) ||
                     ((phase == eth_frame_pkg::PH_DATA) && !last);

    always_comb begin
        norm_rd.ptr_rd  = ptr_rd && (sel == tx_queue_pkg::SEL_NORM);
        norm_rd.data_rd = data_rd && (sel == tx_queue_pkg::SEL_NORM);
        tte_rd.ptr_rd   = ptr_rd && (sel == tx_queue_pkg::SEL_TTE);
        tte_rd.data_rd  = data_rd && (sel == tx_queue_pkg::SEL_TTE);
    end

endmodule

`default_nettype wire

// ==== hdl/gmii_tx_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module gmii_tx_mac #(
    parameter int IFG_BYTES = 12
) (
    input  wire                        tx_master_clk,
    input  wire                        rstn_mac,
    input  wire tx_queue_pkg::queue_in_t norm_q,
    input  wire tx_queue_pkg::queue_in_t tte_q,
    output tx_queue_pkg::queue_rd_t    norm_rd,
    output tx_queue_pkg::queue_rd_t    tte_rd,
    output eth_frame_pkg::gmii_tx_t    gmii
);

    eth_frame_pkg::tx_phase_t          phase;
    tx_queue_pkg::queue_sel_t          sel;
    logic                              load;
    logic [tx_queue_pkg::LEN_W-1:0]    load_value;
    logic                              last;      // final byte of the current phase

    tx_frame_fsm #(
        .IFG_BYTES      (IFG_BYTES)
    ) u_tx_frame_fsm (
        .tx_master_clk  (tx_master_clk),
        .rstn_mac       (rstn_mac),
        .norm_ptr_empty (norm_q.ptr_empty),
        .tte_ptr_empty  (tte_q.ptr_empty),
        .norm_ptr       (norm_q.ptr),
        .tte_ptr        (tte_q.ptr),
        .last           (last),
        .load           (load),
        .load_value     (load_value),
        .phase          (phase),
        .sel            (sel),
        .norm_rd        (norm_rd),
        .tte_rd         (tte_rd)
    );

    // phase lengths are counted here only
    tx_byte_counter u_tx_byte_counter (
        .tx_master_clk  (tx_master_clk),
        .rstn_mac       (rstn_mac),
        .load           (load),
        .load_value     (load_value),
        .last           (last)
    );

    tx_data_path u_tx_data_path (
        .tx_master_clk  (tx_master_clk),
        .rstn_mac       (rstn_mac),
        .phase          (phase),
        .sel            (sel),
        .norm_data      (norm_q.data),
        .tte_data       (tte_q.data),
        .gmii           (gmii)
    );

endmodule

`default_nettype wire

// ==== verif/tb_queue_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_queue_model #(
    parameter string NAME  = "queue",
    parameter int    DEPTH = 4096
) (
    input  wire                          tx_master_clk,
    input  wire tx_queue_pkg::queue_rd_t rd,
    output tx_queue_pkg::queue_in_t      q,
    output int                           rd_errors
);

    logic [7:0]            data_mem [DEPTH];
    tx_queue_pkg::tx_ptr_t ptr_mem [DEPTH];
    int                    d_wr;
    int                    d_rd;
    int                    p_wr;
    int                    p_rd;
    logic [7:0]            data_q;          // registered fifo outputs
    tx_queue_pkg::tx_ptr_t ptr_q;
    logic                  data_rd_s;
    logic                  ptr_rd_s;
    logic                  data_empty_s;
    logic                  ptr_empty_s;

    initial begin
        d_wr      = 0;
        d_rd      = 0;
        p_wr      = 0;
        p_rd      = 0;
        data_q    = '0;
        ptr_q     = '0;
        rd_errors = 0;
    end

    assign q.data       = data_q;
    assign q.data_empty = (d_wr == d_rd);
    assign q.ptr        = ptr_q;
    assign q.ptr_empty  = (p_wr == p_rd);

    ////////////////////////////////////////////////////////////
    // read side, word shows up one cycle after the strobe
    ////////////////////////////////////////////////////////////

    always @(posedge tx_master_clk) begin
        data_rd_s    = rd.data_rd;
        ptr_rd_s     = rd.ptr_rd;
        data_empty_s = q.data_empty;
        ptr_empty_s  = q.ptr_empty;
        #1;
        if (ptr_rd_s) begin
            if (ptr_empty_s) begin
                $display("%0t: %s pointer FIFO read while empty", $time, NAME);
                rd_errors++;
            end else begin
                ptr_q = ptr_mem[p_rd % DEPTH];
                p_rd++;
            end
        end
        if (data_rd_s) begin
            if (data_empty_s) begin
                $display("%0t: %s data FIFO read while empty", $time, NAME);
                rd_errors++;
            end else begin
                data_q = data_mem[d_rd % DEPTH];
                d_rd++;
            end
        end
    end

    // write side, called from the testbench
    task automatic push_byte(input logic [7:0] b);
        data_mem[d_wr % DEPTH] = b;
        d_wr++;
    endtask

    task automatic push_desc(input int len);
        tx_queue_pkg::tx_ptr_t p;
        p.rsvd = '0;
        p.len  = tx_queue_pkg::LEN_W'(len);
        ptr_mem[p_wr % DEPTH] = p;
        p_wr++;
    endtask

endmodule

`default_nettype wire

// ==== verif/tb_gmii_tx_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_gmii_tx_mac;

    localparam int IFG_BYTES = 12;
    localparam int N_STRESS  = 40;

    typedef logic [7:0] byte_q_t[$];

    logic                    tx_master_clk;
    logic                    rstn_mac;
    tx_queue_pkg::queue_in_t norm_q;
    tx_queue_pkg::queue_in_t tte_q;
    tx_queue_pkg::queue_rd_t norm_rd;
    tx_queue_pkg::queue_rd_t tte_rd;
    eth_frame_pkg::gmii_tx_t gmii;
    int                      norm_fifo_err;
    int                      tte_fifo_err;

    integer  seed;
    int      errors;
    int      timeouts;
    byte_q_t exp_norm_b;        // expected wire bytes, frames back to back
    int      exp_norm_n[$];     // frame sizes on the wire
    byte_q_t exp_tte_b;
    int      exp_tte_n[$];
    byte_q_t burst;
    int      seen_src[$];       // 0 normal, 1 tte, -1 no match
    int      seen_len[$];
    int      gap;
    bit      had_frame;

    initial tx_master_clk = 1'b0;
    always #10 tx_master_clk = ~tx_master_clk;

    gmii_tx_mac #(
        .IFG_BYTES     (IFG_BYTES)
    ) DUT (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .norm_q        (norm_q),
        .tte_q         (tte_q),
        .norm_rd       (norm_rd),
        .tte_rd        (tte_rd),
        .gmii          (gmii)
    );

    tb_queue_model #(.NAME("normal")) u_norm_fifo (
        .tx_master_clk (tx_master_clk),
        .rd            (norm_rd),
        .q             (norm_q),
        .rd_errors     (norm_fifo_err)
    );

    tb_queue_model #(.NAME("tte")) u_tte_fifo (
        .tx_master_clk (tx_master_clk),
        .rd            (tte_rd),
        .q             (tte_q),
        .rd_errors     (tte_fifo_err)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] ref_fcs(input byte_q_t pl);
        logic [31:0] c;
        c = eth_frame_pkg::CRC_INIT;
        foreach (pl[i]) begin
            c = c ^ {24'h0, pl[i]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ eth_frame_pkg::CRC_POLY) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic byte_q_t ref_frame(input byte_q_t pl);
        byte_q_t     fr;
        logic [31:0] fcs;
        fcs = ref_fcs(pl);
        for (int i = 0; i < 7; i++) begin
            fr.push_back(8'h55);
        end
        fr.push_back(8'hd5);    // sfd
        foreach (pl[i]) begin
            fr.push_back(pl[i]);
        end
        for (int i = 0; i < 4; i++) begin
            fr.push_back(fcs[8*i +: 8]);    // low byte first
        end
        return fr;
    endfunction

    function automatic bit frame_equal(input byte_q_t got, input byte_q_t exp, input int n);
        if (got.size() != n) begin
            return 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            if (got[i] !== exp[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // standard check value of the 802.3 crc
    task automatic check_reference();
        byte_q_t pl;
        for (int i = 0; i < 9; i++) begin
            pl.push_back(8'h31 + 8'(i));
        end
        if (ref_fcs(pl) != 32'hcbf43926) begin
            $display("ERR %0t: reference crc gives %h", $time, ref_fcs(pl));
            errors++;
        end
    endtask

    task automatic send_frame(input int src, input int len);
        byte_q_t pl;
        byte_q_t fr;
        for (int i = 0; i < len; i++) begin
            pl.push_back(8'($random(seed)));
        end
        fr = ref_frame(pl);
        if (src == 1) begin
            foreach (fr[i]) begin
                exp_tte_b.push_back(fr[i]);
            end
            exp_tte_n.push_back(fr.size());
            foreach (pl[i]) begin
                u_tte_fifo.push_byte(pl[i]);
            end
            u_tte_fifo.push_desc(len);
        end else begin
            foreach (fr[i]) begin
                exp_norm_b.push_back(fr[i]);
            end
            exp_norm_n.push_back(fr.size());
            foreach (pl[i]) begin
                u_norm_fifo.push_byte(pl[i]);
            end
            u_norm_fifo.push_desc(len);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////

    task automatic check_burst();
        bit tte_hit;
        bit norm_hit;
        tte_hit  = 1'b0;
        norm_hit = 1'b0;
        if (exp_tte_n.size() != 0) begin
            tte_hit = frame_equal(burst, exp_tte_b, exp_tte_n[0]);
        end
        if (exp_norm_n.size() != 0) begin
            norm_hit = frame_equal(burst, exp_norm_b, exp_norm_n[0]);
        end
        if (tte_hit) begin
            repeat (exp_tte_n[0]) begin
                void'(exp_tte_b.pop_front());
            end
            void'(exp_tte_n.pop_front());
            seen_src.push_back(1);
        end else if (norm_hit) begin
            repeat (exp_norm_n[0]) begin
                void'(exp_norm_b.pop_front());
            end
            void'(exp_norm_n.pop_front());
            seen_src.push_back(0);
        end else begin
            $display("ERR %0t: frame of %0d bytes matches no queue head", $time, burst.size());
            errors++;
            seen_src.push_back(-1);
        end
        seen_len.push_back(burst.size());
    endtask

    // gmii is registered, negedge is a quiet point
    always @(negedge tx_master_clk) begin
        if (!rstn_mac) begin
            burst.delete();
            had_frame = 1'b0;
            gap       = 0;
        end else if (gmii.dv) begin
            if (burst.size() == 0 && had_frame && gap < IFG_BYTES) begin
                $display("ERR %0t: gap of %0d cycles, need %0d", $time, gap, IFG_BYTES);
                errors++;
            end
            burst.push_back(gmii.d);
        end else begin
            if (burst.size() != 0) begin
                check_burst();
                burst.delete();
                had_frame = 1'b1;
                gap       = 0;
            end
            gap++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge tx_master_clk);
        #1;
    endtask

    task automatic wait_drained(input int limit, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < limit; i++) begin
            if (exp_norm_n.size() == 0 && exp_tte_n.size() == 0) begin
                ok = 1'b1;
                break;
            end
            next_cycle();
        end
        if (!ok) begin
            $display("timeout: %0d normal and %0d tte frames still missing after %0d cycles",
                     exp_norm_n.size(), exp_tte_n.size(), limit);
            timeouts++;
        end
    endtask

    task automatic run_tests();
        bit ok;
        int base;
        int src;
        int len;
        int idle;
        // both queues empty, nothing may move
        for (int i = 0; i < 50; i++) begin
            next_cycle();
            if (gmii.dv || norm_rd != '0 || tte_rd != '0) begin
                $display("ERR %0t: activity with both queues empty", $time);
                errors++;
            end
        end
        send_frame(0, 60);
        wait_drained(2000, ok);
        if (!ok) begin
            return;
        end
        if (seen_len.size() != 1 || seen_len[0] != 72 || seen_src[0] != 0) begin
            $display("ERR %0t: single 60 byte frame not seen as 72 byte burst", $time);
            errors++;
        end
        // priority, both pending at reset release
        next_cycle();
        rstn_mac = 1'b0;
        base     = seen_src.size();
        send_frame(0, 20);
        send_frame(1, 30);
        next_cycle();
        next_cycle();
        rstn_mac = 1'b1;
        wait_drained(2000, ok);
        if (!ok) begin
            return;
        end
        if (seen_src.size() != base + 2 || seen_src[base] != 1 || seen_src[base+1] != 0) begin
            $display("ERR %0t: tte frame not transmitted first", $time);
            errors++;
        end
        // stress
        base = seen_src.size();
        for (int n = 0; n < N_STRESS; n++) begin
            src  = $unsigned($random(seed)) % 2;
            len  = 1 + $unsigned($random(seed)) % 64;
            idle = $unsigned($random(seed)) % 40;
            send_frame(src, len);
            repeat (idle) begin
                next_cycle();
            end
        end
        wait_drained(20000, ok);
        if (!ok) begin
            return;
        end
        if (seen_src.size() != base + N_STRESS) begin
            $display("ERR %0t: %0d stress frames seen", $time, seen_src.size() - base);
            errors++;
        end
    endtask

    initial begin
        seed      = 32'he62e;
        errors    = 0;
        timeouts  = 0;
        gap       = 0;
        had_frame = 1'b0;
        rstn_mac  = 1'b0;
        check_reference();
        repeat (2) begin
            @(posedge tx_master_clk);
        end
        #1;
        rstn_mac = 1'b1;
        run_tests();
        $display("errors: %0d checks, %0d fifo, %0d timeouts",
                 errors, norm_fifo_err + tte_fifo_err, timeouts);
        if (errors == 0 && timeouts == 0 && norm_fifo_err + tte_fifo_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/eth_frame_pkg.sv
common/tx_queue_pkg.sv
crc/crc32_8023.sv
hdl/tx_byte_counter.sv
hdl/tx_data_path.sv
hdl/tx_frame_fsm.sv
hdl/gmii_tx_mac.sv
verif/tb_queue_model.sv
verif/tb_gmii_tx_mac.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gmii transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_gmii_tx_mac \
    -f sources.f -o sim_gmii_tx_mac
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_gmii_tx_mac > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi

exit 0
